// File: src/iq_cfg_pkg.sv
`default_nettype none

package iq_cfg_pkg;

   // queue geometry, one entry per macro row
   localparam int IQ_DEPTH  = 32;
   localparam int IQ_ADR_W  = 5;
   localparam int IQ_DATA_W = 108;

   // word enables are bit interleaved: data bit i sits in lane i mod 4
   localparam int IQ_LANES  = 4;

   // credits the consumer hands to the egress side out of reset
   localparam int IQ_OUT_CREDITS = 4;

   // wide enough to hold a full queue count of IQ_DEPTH
   localparam int IQ_CNT_W  = 6;

endpackage

`default_nettype wire

// File: src/iq_types_pkg.sv
`default_nettype none

package iq_types_pkg;

   import iq_cfg_pkg::*;

   // ingress opcodes
   typedef enum logic [1:0] {
      IQ_OP_NOP   = 2'd0,
      IQ_OP_PUSH  = 2'd1,
      IQ_OP_PATCH = 2'd2
   } iq_op_e;

   // tag carried alongside each macro read
   typedef enum logic [1:0] {
      RD_IDLE = 2'd0,
      RD_DEQ  = 2'd1,
      RD_PEEK = 2'd2
   } iq_rd_state_e;

   // producer request, 114 bits
   typedef struct packed {
      iq_op_e                op;
      logic [IQ_LANES-1:0]   lane_mask;
      logic [IQ_DATA_W-1:0]  data;
   } iq_req_t;

   // macro write port
   typedef struct packed {
      logic                  wr_en;
      logic [IQ_LANES-1:0]   word_wen;
      logic [IQ_ADR_W-1:0]   wr_adr;
      logic [IQ_DATA_W-1:0]  din;
   } iq_wr_t;

   // macro read port, sel_rdaddr1 picks rd_adr1 over rd_adr2
   typedef struct packed {
      logic                  read_en;
      logic                  sel_rdaddr1;
      logic [IQ_ADR_W-1:0]   rd_adr1;
      logic [IQ_ADR_W-1:0]   rd_adr2;
   } iq_rd_t;

endpackage

`default_nettype wire

// File: src/iq_rf32x108.sv
`timescale 1ns/1ps
`default_nettype none

module iq_rf32x108
   import iq_cfg_pkg::*, iq_types_pkg::*;
(
   input  logic                  rclk,
   input  logic                  reset_l,
   input  iq_wr_t                wr,
   input  iq_rd_t                rd,
   output logic [IQ_DATA_W-1:0]  dout
);

   // storage array, contents survive reset
   logic [IQ_DATA_W-1:0]  ary [IQ_DEPTH];

   logic [IQ_DATA_W-1:0]  bit_en;
   logic [IQ_ADR_W-1:0]   rd_adr_sel;
   logic [IQ_ADR_W-1:0]   rdptr_d1;
   logic                  ren_d1;

   //////////////////////////////////////////////////////////////////////
   // write port
   //////////////////////////////////////////////////////////////////////

   // expand word enables to per-bit enables, lane i mod 4
   always_comb begin
      for (int i = 0; i < IQ_DATA_W; i++) begin
         bit_en[i] = wr.word_wen[i % IQ_LANES];
      end
   end

   // only the enabled lanes change, others keep their old value
   always_ff @(posedge rclk) begin
      if (!reset_l && wr.wr_en) begin
         ary[wr.wr_adr] <= (ary[wr.wr_adr] & ~bit_en) | (wr.din & bit_en);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read port
   //////////////////////////////////////////////////////////////////////

   // two-way address select ahead of the read flop
   assign rd_adr_sel = rd.sel_rdaddr1 ? rd.rd_adr1 : rd.rd_adr2;

   always_ff @(posedge rclk) begin
      if (reset_l) begin
         ren_d1 <= 1'b0;
      end else begin
         ren_d1 <= rd.read_en;
      end
   end

   always_ff @(posedge rclk) begin
      rdptr_d1 <= rd_adr_sel;
   end

   // output is zero while no read is registered, so also during reset
   assign dout = ren_d1 ? ary[rdptr_d1] : '0;

   // the egress block must hold back any read that hits a write captured
   // on the same edge
   a_no_rw_collision : assert property (
      @(posedge rclk) disable iff (reset_l)
      (rd.read_en && wr.wr_en) |-> (rd_adr_sel != wr.wr_adr)
   ) else $error("iq_rf32x108: read and write to slot %0d collide", wr.wr_adr);

endmodule

`default_nettype wire

// File: src/iq_wr_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module iq_wr_ctl
   import iq_cfg_pkg::*, iq_types_pkg::*;
(
   input  logic     rclk,
   input  logic     reset_l,
   input  iq_req_t  in_req,
   input  logic     deq_pulse,
   output iq_wr_t   wr,
   output logic     wr_commit,
   output logic     patch_drop
);

   iq_req_t               req_q;
   logic [IQ_ADR_W-1:0]   wr_ptr;
   logic [IQ_CNT_W-1:0]   q_cnt;

   logic                  is_push;
   logic                  is_patch;
   logic                  patch_ok;

   //////////////////////////////////////////////////////////////////////
   // request register
   //////////////////////////////////////////////////////////////////////

   // the registered opcode decides what the request does
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         req_q.op <= IQ_OP_NOP;
      end else begin
         req_q <= in_req;
      end
   end

   assign is_push  = (req_q.op == IQ_OP_PUSH);
   assign is_patch = (req_q.op == IQ_OP_PATCH);

   // a patch needs a queued entry to land on
   assign patch_ok   = is_patch && (q_cnt != '0);
   assign patch_drop = is_patch && (q_cnt == '0);

   //////////////////////////////////////////////////////////////////////
   // macro write port
   //////////////////////////////////////////////////////////////////////

   // push fills all lanes at wr_ptr, patch hits the newest entry
   always_comb begin
      wr.wr_en    = is_push || patch_ok;
      wr.word_wen = is_push ? '1 : req_q.lane_mask;
      wr.wr_adr   = is_push ? wr_ptr : wr_ptr - 1'b1;
      wr.din      = req_q.data;
   end

   //////////////////////////////////////////////////////////////////////
   // pointer and queued count
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (reset_l) begin
         wr_ptr    <= '0;
         q_cnt     <= '0;
         wr_commit <= 1'b0;
      end else begin
         wr_ptr    <= wr_ptr + IQ_ADR_W'(is_push);
         q_cnt     <= q_cnt + IQ_CNT_W'(is_push) - IQ_CNT_W'(deq_pulse);
         // macro takes the push on this edge, egress may read it next cycle
         wr_commit <= is_push;
      end
   end

   // producer credits cap the queue at IQ_DEPTH entries
   a_no_push_when_full : assert property (
      @(posedge rclk) disable iff (reset_l)
      is_push |-> (q_cnt != IQ_CNT_W'(IQ_DEPTH))
   ) else $error("iq_wr_ctl: push with %0d entries queued", q_cnt);

endmodule

`default_nettype wire

// File: src/iq_rd_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module iq_rd_ctl
   import iq_cfg_pkg::*, iq_types_pkg::*;
(
   input  logic                  rclk,
   input  logic                  reset_l,
   input  iq_wr_t                wr,
   input  logic                  wr_commit,
   input  logic                  out_credit,
   input  logic                  peek_req,
   input  logic [IQ_ADR_W-1:0]   peek_adr,
   input  logic [IQ_DATA_W-1:0]  dout,
   output iq_rd_t                rd,
   output logic                  deq_pulse,
   output logic                  in_credit,
   output logic                  out_valid,
   output logic [IQ_DATA_W-1:0]  out_data,
   output logic                  peek_valid,
   output logic [IQ_DATA_W-1:0]  peek_data
);

   logic [IQ_CNT_W-1:0]   avail_cnt;
   logic [IQ_ADR_W-1:0]   rd_ptr;
   logic [IQ_CNT_W-1:0]   cred;
   logic                  peek_pend;
   logic [IQ_ADR_W-1:0]   peek_adr_q;
   iq_rd_state_e          tag_s1;
   iq_rd_state_e          tag_s2;

   logic                  can_deq;
   logic                  issue_peek;

   //////////////////////////////////////////////////////////////////////
   // read arbitration
   //////////////////////////////////////////////////////////////////////

   // reads wait while the pending write targets the same slot
   assign can_deq = (avail_cnt != '0) && (cred != '0)
                    && !(wr.wr_en && (wr.wr_adr == rd_ptr));

   // peek only gets the port when no dequeue wants it
   assign issue_peek = peek_pend && !can_deq
                       && !(wr.wr_en && (wr.wr_adr == peek_adr_q));

   always_comb begin
      rd.read_en     = can_deq || issue_peek;
      rd.sel_rdaddr1 = can_deq;
      rd.rd_adr1     = rd_ptr;
      rd.rd_adr2     = peek_adr_q;
   end

   assign deq_pulse = can_deq;

   //////////////////////////////////////////////////////////////////////
   // counts, pointer, peek request and tag pipeline
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (reset_l) begin
         avail_cnt <= '0;
         rd_ptr    <= '0;
         cred      <= IQ_CNT_W'(IQ_OUT_CREDITS);
         peek_pend <= 1'b0;
         in_credit <= 1'b0;
         tag_s1    <= RD_IDLE;
         tag_s2    <= RD_IDLE;
      end else begin
         avail_cnt <= avail_cnt + IQ_CNT_W'(wr_commit) - IQ_CNT_W'(can_deq);
         rd_ptr    <= rd_ptr + IQ_ADR_W'(can_deq);
         cred      <= cred + IQ_CNT_W'(out_credit) - IQ_CNT_W'(can_deq);
         peek_pend <= peek_req || (peek_pend && !issue_peek);
         // slot freed, hand the producer its credit back
         in_credit <= can_deq;
         // s1 marks the read inside the macro, s2 the result in the out regs
         tag_s1    <= can_deq ? RD_DEQ : (issue_peek ? RD_PEEK : RD_IDLE);
         tag_s2    <= tag_s1;
      end
   end

   always_ff @(posedge rclk) begin
      if (peek_req) begin
         peek_adr_q <= peek_adr;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // output registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (tag_s1 == RD_DEQ) begin
         out_data <= dout;
      end
      if (tag_s1 == RD_PEEK) begin
         peek_data <= dout;
      end
   end

   assign out_valid  = (tag_s2 == RD_DEQ);
   assign peek_valid = (tag_s2 == RD_PEEK);

   // consumer never returns more credits than it was given
   a_cred_bound : assert property (
      @(posedge rclk) disable iff (reset_l)
      cred <= IQ_CNT_W'(IQ_OUT_CREDITS)
   ) else $error("iq_rd_ctl: credit count %0d over limit", cred);

endmodule

`default_nettype wire

// File: src/iq_top.sv
`timescale 1ns/1ps
`default_nettype none

module iq_top
   import iq_cfg_pkg::*, iq_types_pkg::*;
(
   input  logic                  rclk,
   input  logic                  reset_l,
   input  iq_req_t               in_req,
   output logic                  in_credit,
   output logic                  out_valid,
   output logic [IQ_DATA_W-1:0]  out_data,
   input  logic                  out_credit,
   input  logic                  peek_req,
   input  logic [IQ_ADR_W-1:0]   peek_adr,
   output logic                  peek_valid,
   output logic [IQ_DATA_W-1:0]  peek_data,
   output logic                  patch_drop
);

   iq_wr_t                wr_bus;
   iq_rd_t                rd_bus;
   logic [IQ_DATA_W-1:0]  rf_dout;
   logic                  wr_commit;
   logic                  deq_pulse;

   // ingress side, also exports the pending write to egress
   iq_wr_ctl u_wr_ctl (
      .rclk       (rclk),
      .reset_l    (reset_l),
      .in_req     (in_req),
      .deq_pulse  (deq_pulse),
      .wr         (wr_bus),
      .wr_commit  (wr_commit),
      .patch_drop (patch_drop)
   );

   // egress side with peek
   iq_rd_ctl u_rd_ctl (
      .rclk       (rclk),
      .reset_l    (reset_l),
      .wr         (wr_bus),
      .wr_commit  (wr_commit),
      .out_credit (out_credit),
      .peek_req   (peek_req),
      .peek_adr   (peek_adr),
      .dout       (rf_dout),
      .rd         (rd_bus),
      .deq_pulse  (deq_pulse),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .peek_valid (peek_valid),
      .peek_data  (peek_data)
   );

   iq_rf32x108 u_rf (
      .rclk    (rclk),
      .reset_l (reset_l),
      .wr      (wr_bus),
      .rd      (rd_bus),
      .dout    (rf_dout)
   );

endmodule

`default_nettype wire

// File: tests/tb_iq_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_iq_top
   import iq_cfg_pkg::*, iq_types_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 4000;

   logic                  rclk = 1'b0;
   logic                  reset_l;
   iq_req_t               in_req;
   logic                  in_credit;
   logic                  out_valid;
   logic [IQ_DATA_W-1:0]  out_data;
   logic                  out_credit;
   logic                  peek_req;
   logic [IQ_ADR_W-1:0]   peek_adr;
   logic                  peek_valid;
   logic [IQ_DATA_W-1:0]  peek_data;
   logic                  patch_drop;

   // reference queue model
   logic [IQ_DATA_W-1:0]  model_slot [IQ_DEPTH];
   logic [IQ_DATA_W-1:0]  exp_q [$];
   logic [IQ_DATA_W-1:0]  peek_q [$];
   logic [IQ_ADR_W-1:0]   model_wp = '0;
   logic [31:0]           lcg_state = 32'h29ba5a91;

   int errors, out_cnt, peek_cnt, in_credit_cnt, drop_cnt, drop_exp;
   int push_cnt, cred_given, cycle_cnt;

   iq_top u_iq_top (
      .rclk       (rclk),
      .reset_l    (reset_l),
      .in_req     (in_req),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_credit (out_credit),
      .peek_req   (peek_req),
      .peek_adr   (peek_adr),
      .peek_valid (peek_valid),
      .peek_data  (peek_data),
      .patch_drop (patch_drop)
   );

   always #2 rclk = ~rclk;

   always @(posedge rclk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   task automatic check_val(input string name, input logic [IQ_DATA_W-1:0] got,
                            input logic [IQ_DATA_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      end
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [IQ_DATA_W-1:0] rand_entry();
      logic [127:0] raw;
      raw = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      return raw[IQ_DATA_W-1:0];
   endfunction

   // bit i takes the new value when lane i mod 4 is selected
   function automatic logic [IQ_DATA_W-1:0] apply_lanes(input logic [IQ_DATA_W-1:0] old_d,
                                                        input logic [IQ_DATA_W-1:0] new_d,
                                                        input logic [IQ_LANES-1:0] mask);
      logic [IQ_DATA_W-1:0] res;
      for (int i = 0; i < IQ_DATA_W; i++) begin
         res[i] = mask[i % IQ_LANES] ? new_d[i] : old_d[i];
      end
      return res;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge rclk);
   endtask

   task automatic send_req(input iq_op_e op, input logic [IQ_LANES-1:0] mask,
                           input logic [IQ_DATA_W-1:0] data);
      iq_req_t req;
      req.op        = op;
      req.lane_mask = mask;
      req.data      = data;
      @(posedge rclk);
      in_req <= req;
   endtask

   task automatic go_idle();
      send_req(IQ_OP_NOP, '0, '0);
   endtask

   // producer side, one credit per push
   task automatic push_entry(input logic [IQ_DATA_W-1:0] data);
      while (push_cnt - in_credit_cnt >= IQ_DEPTH) begin
         go_idle();
      end
      send_req(IQ_OP_PUSH, '1, data);
      push_cnt++;
      model_slot[model_wp] = data;
      model_wp = model_wp + 5'd1;
      exp_q.push_back(data);
   endtask

   task automatic patch_entry(input logic [IQ_LANES-1:0] mask,
                              input logic [IQ_DATA_W-1:0] data);
      logic [IQ_DATA_W-1:0] merged;
      send_req(IQ_OP_PATCH, mask, data);
      if (exp_q.size() == 0) begin
         drop_exp++;
      end else begin
         merged = apply_lanes(exp_q[exp_q.size()-1], data, mask);
         exp_q[exp_q.size()-1] = merged;
         model_slot[model_wp - 5'd1] = merged;
      end
   endtask

   // consumer hands back a credit only for an entry it has received
   task automatic return_credits(input int n);
      repeat (n) begin
         while (cred_given >= out_cnt) @(posedge rclk);
         @(posedge rclk);
         out_credit <= 1'b1;
         @(posedge rclk);
         out_credit <= 1'b0;
         cred_given++;
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) @(posedge rclk);
   endtask

   //////////////////////////////////////////////////////////////////////
   // output monitor
   //////////////////////////////////////////////////////////////////////

   always @(posedge rclk) begin
      if (!reset_l) begin
         if (in_credit) begin
            in_credit_cnt++;
         end
         if (patch_drop) begin
            drop_cnt++;
         end
         if (out_valid) begin
            out_cnt++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("out_valid seen while no entry was expected");
            end else begin
               check_val("out_data", out_data, exp_q.pop_front());
            end
         end
         if (peek_valid) begin
            peek_cnt++;
            if (peek_q.size() == 0) begin
               errors++;
               $display("peek_valid seen without an open peek request");
            end else begin
               check_val("peek_data", peek_data, peek_q.pop_front());
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_reset_state();
      repeat (5) begin
         @(posedge rclk);
         check_val("out_valid", IQ_DATA_W'(out_valid), '0);
         check_val("peek_valid", IQ_DATA_W'(peek_valid), '0);
         check_val("in_credit", IQ_DATA_W'(in_credit), '0);
      end
   endtask

   task automatic test_order();
      repeat (10) push_entry(rand_entry());
      go_idle();
      return_credits(10);
      wait_drained();
   endtask

   task automatic test_backpressure();
      int out_base;
      int ic_base;
      out_base = out_cnt;
      ic_base  = in_credit_cnt;
      repeat (IQ_DEPTH) push_entry(rand_entry());
      go_idle();
      while (out_cnt < out_base + IQ_OUT_CREDITS) @(posedge rclk);
      wait_cycles(20);
      check_val("out_valid count", IQ_DATA_W'(out_cnt - out_base),
                IQ_DATA_W'(IQ_OUT_CREDITS));
      return_credits(IQ_DEPTH - IQ_OUT_CREDITS);
      wait_drained();
      check_val("in_credit count", IQ_DATA_W'(in_credit_cnt - ic_base),
                IQ_DATA_W'(IQ_DEPTH));
   endtask

   task automatic test_patch();
      logic [31:0]          r;
      logic [IQ_LANES-1:0]  mask;
      int                   out_base;
      r    = lcg_next();
      mask = r[3:0];
      if (mask == '0) begin
         mask = 4'h5;
      end
      out_base = out_cnt;
      push_entry(rand_entry());
      patch_entry(mask, rand_entry());
      go_idle();
      wait_cycles(8);
      check_val("out_valid count", IQ_DATA_W'(out_cnt), IQ_DATA_W'(out_base));
      return_credits(1);
      wait_drained();
   endtask

   task automatic test_patch_drop();
      logic [IQ_DATA_W-1:0] out_d;
      logic [IQ_DATA_W-1:0] peek_d;
      int                   out_base;
      int                   peek_base;
      int                   ic_base;
      wait_cycles(4);
      out_d     = out_data;
      peek_d    = peek_data;
      out_base  = out_cnt;
      peek_base = peek_cnt;
      ic_base   = in_credit_cnt;
      patch_entry(4'hf, rand_entry());
      go_idle();
      wait_cycles(8);
      check_val("patch_drop count", IQ_DATA_W'(drop_cnt), IQ_DATA_W'(drop_exp));
      check_val("out_data", out_data, out_d);
      check_val("peek_data", peek_data, peek_d);
      check_val("out_valid count", IQ_DATA_W'(out_cnt), IQ_DATA_W'(out_base));
      check_val("peek_valid count", IQ_DATA_W'(peek_cnt), IQ_DATA_W'(peek_base));
      check_val("in_credit count", IQ_DATA_W'(in_credit_cnt), IQ_DATA_W'(ic_base));
   endtask

   // every slot holds data by now, so all of them are peeked
   task automatic test_peek();
      int peek_base;
      peek_base = peek_cnt;
      repeat (8) push_entry(rand_entry());
      go_idle();
      wait_cycles(4);
      for (int a = 0; a < IQ_DEPTH; a++) begin
         peek_q.push_back(model_slot[a]);
         @(posedge rclk);
         peek_req <= 1'b1;
         peek_adr <= IQ_ADR_W'(a);
         @(posedge rclk);
         peek_req <= 1'b0;
         while (peek_cnt < peek_base + a + 1) @(posedge rclk);
      end
      wait_cycles(6);
      check_val("peek_valid count", IQ_DATA_W'(peek_cnt - peek_base), IQ_DATA_W'(IQ_DEPTH));
      return_credits(8);
      wait_drained();
   endtask

   initial begin
      reset_l    = 1'b1;
      in_req     = '0;
      out_credit = 1'b0;
      peek_req   = 1'b0;
      peek_adr   = '0;
      repeat (10) @(posedge rclk);
      reset_l <= 1'b0;
      test_reset_state();
      test_order();
      test_backpressure();
      test_patch();
      test_patch_drop();
      test_peek();
      wait_cycles(4);
      $display("done: %0d errors, %0d entries out, %0d peeks, %0d patch drops",
               errors, out_cnt, peek_cnt, drop_cnt);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: iq_top.f
src/iq_cfg_pkg.sv
src/iq_types_pkg.sv
src/iq_rf32x108.sv
src/iq_wr_ctl.sv
src/iq_rd_ctl.sv
src/iq_top.sv
tests/tb_iq_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_iq_top
FILELIST  ?= iq_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
